//--- sim.f
common/serdes_pkg.sv
src/word_timer.sv
src/link_train_fsm.sv
lane/lane_serializer.sv
lane/lane_deserializer.sv
src/sd_port_regs.sv
src/emmc_serdes_link.sv
bench/emmc_serdes_link_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the loopback testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=emmc_serdes_link_sim

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f sim.f --top-module emmc_serdes_link_tb -Mdir obj_dir -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- bench/emmc_serdes_link_tb.sv
`timescale 1ns/1ns

module emmc_serdes_link_tb import serdes_pkg::*; ();

    localparam word_t TRAIN_PATTERN = 8'hC3;
    localparam int    SETTLE_WORDS  = 2;
    localparam int    SEED          = 30268;
    localparam int    NUM_VEC       = 32;               // Every cmd and dat combination
    localparam int    HOLD_CYCLES   = 4 * WORD_W;       // Four word periods per entry
    // WORD_W slips of SETTLE_WORDS+2 words each, plus start-up slack
    localparam int    LOCK_LIMIT    = (WORD_W * (SETTLE_WORDS + 2) + 2) * WORD_W;
    localparam int    UNLOCK_LIMIT  = 4 * WORD_W;

    // Stimulus with the pin values the far side should show
    typedef struct packed {
        logic       cmd;
        logic [3:0] dat;
        logic       exp_cmd;
        logic       exp_cmd_t;
        logic [3:0] exp_sd_dat;
        logic       exp_sd_dat_t;
    } vec_t;

    logic       txclk_div      = 1'b0;
    logic       rst;
    logic       train_serial_i = 1'b1;      // Idle line before the first edge
    logic       data_serial_i  = 1'b1;
    logic       cmd_i;
    logic [3:0] sd_dat_i;
    logic       train_serial_o;
    logic       data_serial_o;
    logic       cmd_o;
    logic       cmd_t;
    logic [3:0] sd_dat_o;
    logic       sd_dat_t;
    logic       locked_o;

    logic [SLOT_W-1:0] tb_slot   = '0;      // Mirrors the transmit word phase
    logic [7:0]        train_dly = '1;
    logic [7:0]        data_dly  = '1;
    logic [3:0]        skew;                // Lane skew in bits, shared by both lanes
    logic              train_raw;

    vec_t  vec_tab  [NUM_VEC];
    string name_tab [NUM_VEC];

    always #10 txclk_div = ~txclk_div;      // 20 ns period

    emmc_serdes_link #(
        .TRAIN_PATTERN     (TRAIN_PATTERN),
        .SLIP_SETTLE_WORDS (SETTLE_WORDS)
    ) emmc_serdes_link_inst (
        .txclk_div      (txclk_div),
        .rst            (rst),
        .train_serial_i (train_serial_i),
        .data_serial_i  (data_serial_i),
        .train_serial_o (train_serial_o),
        .data_serial_o  (data_serial_o),
        .cmd_i          (cmd_i),
        .sd_dat_i       (sd_dat_i),
        .cmd_o          (cmd_o),
        .cmd_t          (cmd_t),
        .sd_dat_o       (sd_dat_o),
        .sd_dat_t       (sd_dat_t),
        .locked_o       (locked_o)
    );

    ////////////////////////////////////////////////////////////
    // Loopback model
    ////////////////////////////////////////////////////////////

    // Training bit in step with the data bit now on data_serial_o
    assign train_raw = TRAIN_PATTERN[tb_slot - 3'd1];

    function automatic logic delay_tap(input logic [7:0] dly, input logic raw,
                                       input logic [3:0] bits);
        if (bits == 4'd0) begin
            return raw;
        end else begin
            return dly[3'(bits - 4'd1)];
        end
    endfunction

    always @(posedge txclk_div) begin
        if (!rst) begin
            tb_slot <= '0;
        end else begin
            tb_slot <= tb_slot + 3'd1;
        end
        train_dly      <= {train_dly[6:0], train_raw};
        data_dly       <= {data_dly[6:0], data_serial_o};
        train_serial_i <= delay_tap(train_dly, train_raw, skew);      // Same skew on both
        data_serial_i  <= delay_tap(data_dly, data_serial_o, skew);
    end

    ////////////////////////////////////////////////////////////
    // Expected values and checks
    ////////////////////////////////////////////////////////////

    function automatic vec_t build_entry(input logic [4:0] idx);
        vec_t       v;
        logic [7:0] w;
        v     = '0;
        v.cmd = idx[4];
        v.dat = idx[3:0];
        w = {3'b000, v.dat, v.cmd};         // Sender layout, cmd in bit 0
        // Receiver maps the same word onto its own fields
        v.exp_cmd      = w[0];
        v.exp_cmd_t    = w[1];
        v.exp_sd_dat_t = w[2];
        v.exp_sd_dat   = w[6:3];
        return v;
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string test_name, input string field,
                               input logic [3:0] expected, input logic [3:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s: expected %0h, actual %0h",
                     test_name, field, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_entry(input string test_name, input vec_t v);
        check_value(test_name, "locked_o", 4'd1, 4'(locked_o));
        check_value(test_name, "cmd_o", 4'(v.exp_cmd), 4'(cmd_o));
        check_value(test_name, "cmd_t", 4'(v.exp_cmd_t), 4'(cmd_t));
        check_value(test_name, "sd_dat_o", v.exp_sd_dat, sd_dat_o);
        check_value(test_name, "sd_dat_t", 4'(v.exp_sd_dat_t), 4'(sd_dat_t));
    endtask

    // Poll locked_o at mid-cycle until it reaches the wanted level
    task automatic wait_lock_level(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while ((locked_o !== level) && (n < limit)) begin
            @(negedge txclk_div);
            n++;
        end
        assert (locked_o === level) else begin
            $display("%s after %0d cycles", what, limit);
            abort_run();
        end
    endtask

    // Two words of echo must hold the pattern at some bit offset
    task automatic check_echo();
        logic [15:0] bits;
        logic [15:0] win;
        logic        found;
        bits  = '0;
        found = 1'b0;
        for (int i = 0; i < 2 * WORD_W; i++) begin
            @(negedge txclk_div);
            bits = {train_serial_o, bits[15:1]};   // Oldest bit ends in bit 0
        end
        win = bits;
        for (int i = 0; i <= WORD_W; i++) begin
            if (win[7:0] == TRAIN_PATTERN) begin
                found = 1'b1;
            end
            win = win >> 1;
        end
        assert (found) else begin
            $display("Echo lane did not carry the training word, bits %b", bits);
            abort_run();
        end
    endtask

    task automatic run_table(input string tag);
        for (int i = 0; i < NUM_VEC; i++) begin
            @(posedge txclk_div);
            cmd_i    <= vec_tab[i].cmd;
            sd_dat_i <= vec_tab[i].dat;
            repeat (HOLD_CYCLES) @(posedge txclk_div);
            @(negedge txclk_div);
            check_entry({tag, "/", name_tab[i]}, vec_tab[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst      = 1'b0;
        cmd_i    = 1'b0;
        sd_dat_i = 4'h0;
        void'($urandom(SEED));
        skew     = 4'($urandom_range(7, 0));
        $display("Lane skew %0d bits", skew);

        for (int k = 0; k < NUM_VEC; k++) begin
            vec_tab[k]  = build_entry(5'(k));
            name_tab[k] = $sformatf("cmd%0d_dat%04b", vec_tab[k].cmd, vec_tab[k].dat);
        end

        // Reset state, still before the first edge out of reset
        repeat (9) @(posedge txclk_div);
        @(negedge txclk_div);
        check_value("reset", "locked_o", 4'd0, 4'(locked_o));
        check_value("reset", "cmd_o", 4'd0, 4'(cmd_o));
        check_value("reset", "cmd_t", 4'd0, 4'(cmd_t));
        check_value("reset", "sd_dat_o", 4'd0, sd_dat_o);
        check_value("reset", "sd_dat_t", 4'd0, 4'(sd_dat_t));
        check_value("reset", "train_serial_o", 4'd1, 4'(train_serial_o));
        check_value("reset", "data_serial_o", 4'd1, 4'(data_serial_o));
        @(posedge txclk_div);
        rst <= 1'b1;

        wait_lock_level(1'b1, LOCK_LIMIT, "Link never locked");
        repeat (2 * WORD_W) @(posedge txclk_div);   // Echo register refills
        check_echo();
        run_table("first");

        // One more bit of skew, lock must drop and come back
        @(posedge txclk_div);
        skew <= skew + 4'd1;
        wait_lock_level(1'b0, UNLOCK_LIMIT, "Link kept lock after the extra skew bit");
        wait_lock_level(1'b1, LOCK_LIMIT, "Link never locked again after the extra skew bit");
        run_table("relock");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- src/emmc_serdes_link.sv
`timescale 1ns/1ns

module emmc_serdes_link import serdes_pkg::*; #(
    parameter word_t TRAIN_PATTERN     = DEF_TRAIN_PATTERN,
    parameter int    SLIP_SETTLE_WORDS = DEF_SLIP_SETTLE_WORDS
) (
    input  logic       txclk_div,
    input  logic       rst,             // Synchronous, active low

    // Serial lanes
    input  logic       train_serial_i,
    input  logic       data_serial_i,
    output logic       train_serial_o,  // Echo of the received training word
    output logic       data_serial_o,

    // SD pins
    input  logic       cmd_i,
    input  logic [3:0] sd_dat_i,
    output logic       cmd_o,
    output logic       cmd_t,
    output logic [3:0] sd_dat_o,
    output logic       sd_dat_t,

    output logic       locked_o
);

    logic      tx_word_start;           // Transmit slot 0
    logic      rx_word_done;            // Receive last slot
    logic      bitslip;                 // Moves the receive boundary
    word_t     train_rx_word;           // Training word, to FSM and echo
    tx_frame_t tx_frame;
    rx_frame_t rx_frame;

    ////////////////////////////////////////////////////////////
    // Word timing
    ////////////////////////////////////////////////////////////

    word_timer #(.HAS_SLIP(1'b0)) tx_timer_inst (   // Fixed transmit boundary
        .txclk_div    (txclk_div),
        .rst          (rst),
        .slip_i       (bitslip),
        .word_start_o (tx_word_start),
        .word_done_o  ()
    );

    word_timer #(.HAS_SLIP(1'b1)) rx_timer_inst (
        .txclk_div    (txclk_div),
        .rst          (rst),
        .slip_i       (bitslip),
        .word_start_o (),
        .word_done_o  (rx_word_done)
    );

    link_train_fsm #(
        .TRAIN_PATTERN     (TRAIN_PATTERN),
        .SLIP_SETTLE_WORDS (SLIP_SETTLE_WORDS)
    ) train_fsm_inst (
        .txclk_div    (txclk_div),
        .rst          (rst),
        .word_done_i  (rx_word_done),
        .train_word_i (train_rx_word),
        .bitslip_o    (bitslip),
        .locked_o     (locked_o)
    );

    ////////////////////////////////////////////////////////////
    // Lanes
    ////////////////////////////////////////////////////////////

    lane_deserializer train_deser_inst (
        .txclk_div   (txclk_div),
        .rst         (rst),
        .serial_i    (train_serial_i),
        .word_done_i (rx_word_done),
        .word_o      (train_rx_word)
    );

    lane_serializer train_ser_inst (    // Sends back what was received
        .txclk_div    (txclk_div),
        .rst          (rst),
        .word_start_i (tx_word_start),
        .word_i       (train_rx_word),
        .serial_o     (train_serial_o)
    );

    lane_deserializer data_deser_inst (
        .txclk_div   (txclk_div),
        .rst         (rst),
        .serial_i    (data_serial_i),
        .word_done_i (rx_word_done),
        .word_o      (rx_frame)
    );

    lane_serializer data_ser_inst (
        .txclk_div    (txclk_div),
        .rst          (rst),
        .word_start_i (tx_word_start),
        .word_i       (tx_frame),
        .serial_o     (data_serial_o)
    );

    // Pin registers on both directions
    sd_port_regs sd_regs_inst (
        .txclk_div  (txclk_div),
        .rst        (rst),
        .cmd_i      (cmd_i),
        .sd_dat_i   (sd_dat_i),
        .tx_frame_o (tx_frame),
        .rx_frame_i (rx_frame),
        .cmd_o      (cmd_o),
        .cmd_t      (cmd_t),
        .sd_dat_o   (sd_dat_o),
        .sd_dat_t   (sd_dat_t)
    );

endmodule

//--- src/sd_port_regs.sv
`timescale 1ns/1ns

module sd_port_regs import serdes_pkg::*; (
    input  logic       txclk_div,
    input  logic       rst,

    // Local SD side, toward the link
    input  logic       cmd_i,
    input  logic [3:0] sd_dat_i,
    output tx_frame_t  tx_frame_o,      // To the data-lane serializer

    // Far side, from the link
    input  rx_frame_t  rx_frame_i,      // From the data-lane deserializer
    output logic       cmd_o,
    output logic       cmd_t,
    output logic [3:0] sd_dat_o,
    output logic       sd_dat_t
);

    ////////////////////////////////////////////////////////////
    // Transmit frame packing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            tx_frame_o <= '0;
        end else begin
            tx_frame_o.pad <= '0;       // Upper bits unused
            tx_frame_o.dat <= sd_dat_i;
            tx_frame_o.cmd <= cmd_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Receive frame unpacking onto the pins
    ////////////////////////////////////////////////////////////

    // Sampled every cycle, the frame only changes at word boundaries
    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            cmd_o    <= 1'b0;
            cmd_t    <= 1'b0;
            sd_dat_t <= 1'b0;
            sd_dat_o <= '0;
        end else begin
            cmd_o    <= rx_frame_i.cmd;
            cmd_t    <= rx_frame_i.cmd_t;
            sd_dat_t <= rx_frame_i.dat_t;
            sd_dat_o <= rx_frame_i.dat;     // Pad bit not driven out
        end
    end

endmodule

//--- lane/lane_deserializer.sv
`timescale 1ns/1ns

module lane_deserializer import serdes_pkg::*; (
    input  logic  txclk_div,
    input  logic  rst,
    input  logic  serial_i,             // Incoming lane, LSB first
    input  logic  word_done_i,          // Last slot of the receive word
    output word_t word_o                // Captured word
);

    word_t shift_q;                     // Running window of the last bits
    word_t next_word;                   // Window including this cycle's bit

    // Newest bit lands at the top, so the first bit of a
    // word ends up in bit 0 after WORD_W shifts
    assign next_word = {serial_i, shift_q[WORD_W-1:1]};

    always_ff @(posedge txclk_div) begin
        shift_q <= next_word;
    end

    ////////////////////////////////////////////////////////////
    // Word capture at the receive boundary
    ////////////////////////////////////////////////////////////

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            word_o <= '1;               // Idle line reads all ones
        end else if (word_done_i) begin
            word_o <= next_word;
        end
    end

endmodule

//--- lane/lane_serializer.sv
`timescale 1ns/1ns

module lane_serializer import serdes_pkg::*; (
    input  logic  txclk_div,
    input  logic  rst,
    input  logic  word_start_i,         // Slot 0 of the transmit word
    input  word_t word_i,               // Parallel word to send
    output logic  serial_o              // One bit per cycle, LSB first
);

    word_t shift_q;                     // Bits still waiting to leave

    ////////////////////////////////////////////////////////////
    // Load and shift
    ////////////////////////////////////////////////////////////

    // Bit 0 goes straight to the output register on load,
    // the rest march down behind it
    always_ff @(posedge txclk_div) begin
        if (word_start_i) begin
            shift_q <= {1'b1, word_i[WORD_W-1:1]};
        end else begin
            shift_q <= {1'b1, shift_q[WORD_W-1:1]};   // Fill with idle level
        end
    end

    // Output flop, idle high out of reset
    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            serial_o <= 1'b1;
        end else if (word_start_i) begin
            serial_o <= word_i[0];      // Slot 0 bit, one cycle later
        end else begin
            serial_o <= shift_q[0];
        end
    end

endmodule

//--- src/link_train_fsm.sv
`timescale 1ns/1ns

module link_train_fsm import serdes_pkg::*; #(
    parameter word_t TRAIN_PATTERN     = DEF_TRAIN_PATTERN,
    parameter int    SLIP_SETTLE_WORDS = DEF_SLIP_SETTLE_WORDS   // 1 to 7
) (
    input  logic  txclk_div,
    input  logic  rst,
    input  logic  word_done_i,          // Receive boundary strobe
    input  word_t train_word_i,         // Deserialized training word
    output logic  bitslip_o,            // One-cycle slip pulse
    output logic  locked_o              // Level, high while aligned
);

    localparam int CNT_W = $clog2(SLIP_SETTLE_WORDS + 1);
    localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(SLIP_SETTLE_WORDS - 1);

    train_state_e     state_q;
    train_state_e     state_d;
    logic [CNT_W-1:0] settle_q;         // Words seen since the slip
    logic             done_q;           // Word register valid this cycle
    logic             match;

    assign match = (train_word_i == TRAIN_PATTERN);

    ////////////////////////////////////////////////////////////
    // Next-state logic
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            TRAIN_HUNT, TRAIN_LOCKED: begin
                // Deserializer output is fresh one cycle after the boundary
                if (done_q) begin
                    state_d = match ? TRAIN_LOCKED : TRAIN_SLIP;
                end
            end
            TRAIN_SLIP: begin
                state_d = TRAIN_SETTLE;     // Pulse lasts exactly one cycle
            end
            TRAIN_SETTLE: begin
                if (word_done_i && (settle_q == SETTLE_LAST)) begin
                    state_d = TRAIN_HUNT;
                end
            end
            default: begin
                state_d = TRAIN_HUNT;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State and counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            state_q  <= TRAIN_HUNT;
            settle_q <= '0;
            done_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= word_done_i;
            if (state_q == TRAIN_SLIP) begin
                settle_q <= '0;                 // Restart the wait
            end else if ((state_q == TRAIN_SETTLE) && word_done_i) begin
                settle_q <= settle_q + 1'b1;
            end
        end
    end

    // Outputs decode from the state register
    assign bitslip_o = (state_q == TRAIN_SLIP);
    assign locked_o  = (state_q == TRAIN_LOCKED);

endmodule

//--- src/word_timer.sv
`timescale 1ns/1ns

module word_timer import serdes_pkg::*; #(
    parameter bit HAS_SLIP = 1'b1       // Transmit side runs without slip
) (
    input  logic txclk_div,
    input  logic rst,
    input  logic slip_i,                // Repeat the current slot once
    output logic word_start_o,          // Slot 0
    output logic word_done_o            // Slot WORD_W-1
);

    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(WORD_W - 1);

    logic [SLOT_W-1:0] slot_q;          // Current bit slot
    logic              hold;            // Freeze the count this cycle

    // Slip request only matters on the receive timer
    assign hold = HAS_SLIP ? slip_i : 1'b0;

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            slot_q <= '0;
        end else if (hold) begin
            slot_q <= slot_q;           // Word grows by one bit
        end else if (slot_q == LAST_SLOT) begin
            slot_q <= '0;               // Wrap to next word
        end else begin
            slot_q <= slot_q + 1'b1;
        end
    end

    // Boundary flags decode straight from the count
    assign word_start_o = (slot_q == '0);
    assign word_done_o  = (slot_q == LAST_SLOT);

endmodule

//--- common/serdes_pkg.sv
package serdes_pkg;

    ////////////////////////////////////////////////////////////
    // Word geometry
    ////////////////////////////////////////////////////////////

    localparam int WORD_W = 8;      // Serial bits per word
    localparam int SLOT_W = 3;      // Bit-slot index width

    typedef logic [WORD_W-1:0] word_t;

    ////////////////////////////////////////////////////////////
    // Frame layouts on the data lane
    ////////////////////////////////////////////////////////////

    // Outgoing word, bit 0 leaves first
    typedef struct packed {
        logic [2:0] pad;            // Always zero
        logic [3:0] dat;            // Local SD data pins
        logic       cmd;            // Local command line
    } tx_frame_t;

    // Incoming word as seen by the far side's pin mapping
    typedef struct packed {
        logic       pad;
        logic [3:0] dat;            // Drives sd_dat_o
        logic       dat_t;          // Data-bus direction
        logic       cmd_t;          // Command-line direction
        logic       cmd;            // Command level
    } rx_frame_t;

    ////////////////////////////////////////////////////////////
    // Link training
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        TRAIN_HUNT   = 2'd0,        // Compare each received word
        TRAIN_SLIP   = 2'd1,        // One-cycle bitslip request
        TRAIN_SETTLE = 2'd2,        // Let the new boundary fill
        TRAIN_LOCKED = 2'd3         // Pattern seen at the boundary
    } train_state_e;

    // Not rotation-symmetric, so exactly one boundary matches
    localparam word_t DEF_TRAIN_PATTERN = 8'hC3;

    localparam int DEF_SLIP_SETTLE_WORDS = 2;

endpackage
